// ==== rtl/dispatcher_pkg.sv ====
package dispatcher_pkg;

  // number of cpu slots sharing the memory port
  localparam int CPU_SLOTS = 8;

  // poll index: msb is the new-cpu offer flag, low bits the active cpu number
  localparam int IDX_W = 4;

  // active/inactive counters must hold 0..CPU_SLOTS
  localparam int CNT_W = $clog2(CPU_SLOTS + 1);

  // external memory geometry
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // reply codes sent back by the polled cpu
  typedef enum logic [2:0] {
    MSG_NONE  = 3'd0,
    MSG_START = 3'd1,
    MSG_END   = 3'd2,
    MSG_READ  = 3'd3,
    MSG_WRITE = 3'd4
  } cpu_msg_e;

  // request towards the external memory, 49 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              is_write;
  } mem_req_t;

  // response back to the cpu, 33 bits
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              is_write;
  } mem_rsp_t;

  // dispatcher control states
  typedef enum logic [1:0] {
    ST_POLL       = 2'd0,
    ST_WAIT_REPLY = 2'd1,
    ST_WAIT_MEM   = 2'd2,
    ST_EXT_BUS    = 2'd3
  } sched_state_e;

endpackage

// ==== rtl/cpu_reply_decoder.sv ====
`timescale 1ns/1ps

module cpu_reply_decoder (
  input  logic                              clk,
  input  logic                              ext_rst_e,
  input  logic                              reply_valid,
  input  dispatcher_pkg::cpu_msg_e          reply_msg,
  input  logic [dispatcher_pkg::ADDR_W-1:0] reply_addr,
  input  logic [dispatcher_pkg::DATA_W-1:0] reply_wdata,
  output logic                              reply_ready,
  output logic                              ev_start,
  output logic                              ev_end,
  output logic                              ev_none,
  output logic                              req_valid,
  output dispatcher_pkg::mem_req_t          req_data,
  input  logic                              req_ready
);

  // single reply holding register
  logic                              full_q;
  dispatcher_pkg::cpu_msg_e          msg_q;
  logic [dispatcher_pkg::ADDR_W-1:0] addr_q;
  logic [dispatcher_pkg::DATA_W-1:0] wdata_q;
  logic                              accept;
  logic                              is_mem;
  logic                              is_start;
  logic                              is_end;

  // ready only while the register is empty
  assign reply_ready = ~full_q;
  assign accept      = reply_valid & reply_ready;

  // classify the held message
  assign is_start = (msg_q == dispatcher_pkg::MSG_START);
  assign is_end   = (msg_q == dispatcher_pkg::MSG_END);
  assign is_mem   = (msg_q == dispatcher_pkg::MSG_READ) || (msg_q == dispatcher_pkg::MSG_WRITE);

  // control events last exactly one cycle, the register empties behind them
  assign ev_start = full_q & is_start;
  assign ev_end   = full_q & is_end;
  // unknown codes are treated as none so the poll never stalls
  assign ev_none  = full_q & ~is_mem & ~is_start & ~is_end;

  // memory request held until the request buffer takes it
  assign req_valid = full_q & is_mem;
  assign req_data  = '{
    addr:     addr_q,
    wdata:    wdata_q,
    is_write: (msg_q == dispatcher_pkg::MSG_WRITE)
  };

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (full_q && (!is_mem || req_ready)) begin
      // events drain at once, requests on handover
      full_q <= 1'b0;
    end
  end

  // payload capture on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      msg_q   <= reply_msg;
      addr_q  <= reply_addr;
      wdata_q <= reply_wdata;
    end
  end

endmodule

// ==== rtl/req_buffer.sv ====
`timescale 1ns/1ps

module req_buffer #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     ext_rst_e,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  // output stage plus skid stage
  logic     out_valid_q;
  logic     skid_valid_q;
  payload_t out_data_q;
  payload_t skid_data_q;
  logic     out_free;
  logic     push;

  // ready comes straight from a flop
  assign in_ready  = ~skid_valid_q;
  assign out_valid = out_valid_q;
  assign out_data  = out_data_q;

  // output stage can load this cycle
  assign out_free = out_ready | ~out_valid_q;
  assign push     = in_valid & in_ready;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_free) begin
      // skid entry drains first, otherwise pass input through
      out_valid_q  <= skid_valid_q | in_valid;
      skid_valid_q <= 1'b0;
    end else if (push) begin
      // output stalled, park the new item
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      out_data_q <= skid_valid_q ? skid_data_q : in_data;
    end
    if (push && !out_free) begin
      skid_data_q <= in_data;
    end
  end

endmodule

// ==== rtl/cpu_scheduler.sv ====
`timescale 1ns/1ps

module cpu_scheduler (
  input  logic                             clk,
  input  logic                             ext_rst_e,
  input  logic                             ev_start,
  input  logic                             ev_end,
  input  logic                             ev_none,
  input  logic                             rsp_valid,
  input  logic                             rsp_ready,
  input  logic                             ext_bus_q,
  output logic                             cpu_q,
  output logic [dispatcher_pkg::IDX_W-1:0] cpu_index,
  output logic                             ext_bus_allow
);

  dispatcher_pkg::sched_state_e state_q;

  // cpu accounting
  logic [dispatcher_pkg::CNT_W-1:0] active_q;
  logic [dispatcher_pkg::CNT_W-1:0] inactive_q;
  // round robin pointer over active cpus
  logic [dispatcher_pkg::IDX_W-2:0] ptr_q;
  // last poll offered a slot to a new cpu
  logic                             last_offer_q;

  logic                             offer_next;
  logic [dispatcher_pkg::CNT_W-1:0] ptr_inc;
  logic [dispatcher_pkg::CNT_W-1:0] ptr_nxt;
  logic                             rsp_done;

  // alternate offers while slots remain, always offer with nobody active
  assign offer_next = ((inactive_q != '0) && !last_offer_q) || (active_q == '0);

  // next active cpu, wraps at the active count
  assign ptr_inc = dispatcher_pkg::CNT_W'(ptr_q) + 1'b1;
  assign ptr_nxt = (ptr_inc >= active_q) ? '0 : ptr_inc;

  // response handed to the cpu
  assign rsp_done = rsp_valid & rsp_ready;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state_q       <= dispatcher_pkg::ST_POLL;
      active_q      <= '0;
      inactive_q    <= dispatcher_pkg::CNT_W'(dispatcher_pkg::CPU_SLOTS);
      ptr_q         <= '0;
      last_offer_q  <= 1'b0;
      cpu_q         <= 1'b0;
      cpu_index     <= '0;
      ext_bus_allow <= 1'b0;
    end else begin
      // poll request is a single cycle pulse
      cpu_q <= 1'b0;

      case (state_q)
        dispatcher_pkg::ST_POLL: begin
          if (ext_bus_q) begin
            // hand the bus out between polls
            ext_bus_allow <= 1'b1;
            state_q       <= dispatcher_pkg::ST_EXT_BUS;
          end else begin
            cpu_q <= 1'b1;
            if (offer_next) begin
              cpu_index    <= {1'b1, {(dispatcher_pkg::IDX_W-1){1'b0}}};
              last_offer_q <= 1'b1;
            end else begin
              cpu_index    <= {1'b0, ptr_nxt[dispatcher_pkg::IDX_W-2:0]};
              ptr_q        <= ptr_nxt[dispatcher_pkg::IDX_W-2:0];
              last_offer_q <= 1'b0;
            end
            state_q <= dispatcher_pkg::ST_WAIT_REPLY;
          end
        end

        dispatcher_pkg::ST_WAIT_REPLY: begin
          if (ev_start || ev_end || ev_none) begin
            // start only counts on an offer poll
            if (ev_start && last_offer_q) begin
              active_q   <= active_q + 1'b1;
              inactive_q <= inactive_q - 1'b1;
            end
            // end only counts on a poll of an active cpu
            if (ev_end && !last_offer_q) begin
              active_q   <= active_q - 1'b1;
              inactive_q <= inactive_q + 1'b1;
              ptr_q      <= '0;
            end
            state_q <= dispatcher_pkg::ST_POLL;
          end else if (rsp_done) begin
            state_q <= dispatcher_pkg::ST_POLL;
          end else if (rsp_valid) begin
            // response is out, cpu is stalling it
            state_q <= dispatcher_pkg::ST_WAIT_MEM;
          end
        end

        dispatcher_pkg::ST_WAIT_MEM: begin
          if (rsp_done) begin
            state_q <= dispatcher_pkg::ST_POLL;
          end
        end

        dispatcher_pkg::ST_EXT_BUS: begin
          // allow drops one cycle after the request
          if (!ext_bus_q) begin
            ext_bus_allow <= 1'b0;
            state_q       <= dispatcher_pkg::ST_POLL;
          end
        end

        default: state_q <= dispatcher_pkg::ST_POLL;
      endcase
    end
  end

endmodule

// ==== rtl/ext_mem_port.sv ====
`timescale 1ns/1ps

module ext_mem_port (
  input  logic                              clk,
  input  logic                              ext_rst_e,
  input  logic                              req_valid,
  input  dispatcher_pkg::mem_req_t          req_data,
  output logic                              req_ready,
  output logic                              ext_read_q,
  output logic                              ext_write_q,
  output logic [dispatcher_pkg::ADDR_W-1:0] ext_mem_addr,
  output logic [dispatcher_pkg::DATA_W-1:0] ext_mem_wdata,
  input  logic                              ext_read_dn,
  input  logic                              ext_write_dn,
  input  logic [dispatcher_pkg::DATA_W-1:0] ext_mem_rdata,
  output logic                              rsp_valid,
  output dispatcher_pkg::mem_rsp_t          rsp_data,
  input  logic                              rsp_ready
);

  // outstanding external access
  logic                     rd_q;
  logic                     wr_q;
  logic                     rsp_valid_q;
  dispatcher_pkg::mem_rsp_t rsp_q;
  logic                     take;
  logic                     done;

  // one access in flight, next one only after the response left
  assign req_ready = ~rd_q & ~wr_q & ~rsp_valid_q;
  assign take      = req_valid & req_ready;
  assign done      = (rd_q & ext_read_dn) | (wr_q & ext_write_dn);

  assign ext_read_q  = rd_q;
  assign ext_write_q = wr_q;
  assign rsp_valid   = rsp_valid_q;
  assign rsp_data    = rsp_q;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      rd_q        <= 1'b0;
      wr_q        <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (take) begin
        rd_q <= ~req_data.is_write;
        wr_q <= req_data.is_write;
      end else if (done) begin
        // request drops the cycle after done
        rd_q        <= 1'b0;
        wr_q        <= 1'b0;
        rsp_valid_q <= 1'b1;
      end else if (rsp_valid_q && rsp_ready) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  // address and data held for the whole access
  always_ff @(posedge clk) begin
    if (take) begin
      ext_mem_addr  <= req_data.addr;
      ext_mem_wdata <= req_data.wdata;
    end
    if (done) begin
      rsp_q.rdata    <= wr_q ? '0 : ext_mem_rdata;
      rsp_q.is_write <= wr_q;
    end
  end

endmodule

// ==== rtl/dispatcher_top.sv ====
`timescale 1ns/1ps

module dispatcher_top (
  input  logic                              clk,
  input  logic                              ext_rst_e,
  output logic                              cpu_q,
  output logic [dispatcher_pkg::IDX_W-1:0]  cpu_index,
  input  logic                              reply_valid,
  input  dispatcher_pkg::cpu_msg_e          reply_msg,
  input  logic [dispatcher_pkg::ADDR_W-1:0] reply_addr,
  input  logic [dispatcher_pkg::DATA_W-1:0] reply_wdata,
  output logic                              reply_ready,
  output logic                              rsp_valid,
  output logic [dispatcher_pkg::DATA_W-1:0] rsp_rdata,
  output logic                              rsp_is_write,
  input  logic                              rsp_ready,
  output logic                              ext_read_q,
  output logic                              ext_write_q,
  output logic [dispatcher_pkg::ADDR_W-1:0] ext_mem_addr,
  output logic [dispatcher_pkg::DATA_W-1:0] ext_mem_wdata,
  input  logic                              ext_read_dn,
  input  logic                              ext_write_dn,
  input  logic [dispatcher_pkg::DATA_W-1:0] ext_mem_rdata,
  input  logic                              ext_bus_q,
  output logic                              ext_bus_allow
);

  // decoder to scheduler events
  logic ev_start;
  logic ev_end;
  logic ev_none;

  // decoder to request buffer
  logic                     dec_req_valid;
  logic                     dec_req_ready;
  dispatcher_pkg::mem_req_t dec_req_data;

  // request buffer to memory port
  logic                     mp_req_valid;
  logic                     mp_req_ready;
  dispatcher_pkg::mem_req_t mp_req_data;

  // memory port to response buffer
  logic                     mp_rsp_valid;
  logic                     mp_rsp_ready;
  dispatcher_pkg::mem_rsp_t mp_rsp_data;

  // response buffer output before splitting into fields
  dispatcher_pkg::mem_rsp_t rsp_data;

  assign rsp_rdata    = rsp_data.rdata;
  assign rsp_is_write = rsp_data.is_write;

  cpu_reply_decoder u_decoder (
    .clk         (clk),
    .ext_rst_e   (ext_rst_e),
    .reply_valid (reply_valid),
    .reply_msg   (reply_msg),
    .reply_addr  (reply_addr),
    .reply_wdata (reply_wdata),
    .reply_ready (reply_ready),
    .ev_start    (ev_start),
    .ev_end      (ev_end),
    .ev_none     (ev_none),
    .req_valid   (dec_req_valid),
    .req_data    (dec_req_data),
    .req_ready   (dec_req_ready)
  );

  req_buffer #(.payload_t(dispatcher_pkg::mem_req_t)) u_req_buf (
    .clk       (clk),
    .ext_rst_e (ext_rst_e),
    .in_valid  (dec_req_valid),
    .in_data   (dec_req_data),
    .in_ready  (dec_req_ready),
    .out_valid (mp_req_valid),
    .out_data  (mp_req_data),
    .out_ready (mp_req_ready)
  );

  cpu_scheduler u_scheduler (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .ev_start      (ev_start),
    .ev_end        (ev_end),
    .ev_none       (ev_none),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .ext_bus_q     (ext_bus_q),
    .cpu_q         (cpu_q),
    .cpu_index     (cpu_index),
    .ext_bus_allow (ext_bus_allow)
  );

  ext_mem_port u_mem_port (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .req_valid     (mp_req_valid),
    .req_data      (mp_req_data),
    .req_ready     (mp_req_ready),
    .ext_read_q    (ext_read_q),
    .ext_write_q   (ext_write_q),
    .ext_mem_addr  (ext_mem_addr),
    .ext_mem_wdata (ext_mem_wdata),
    .ext_read_dn   (ext_read_dn),
    .ext_write_dn  (ext_write_dn),
    .ext_mem_rdata (ext_mem_rdata),
    .rsp_valid     (mp_rsp_valid),
    .rsp_data      (mp_rsp_data),
    .rsp_ready     (mp_rsp_ready)
  );

  req_buffer #(.payload_t(dispatcher_pkg::mem_rsp_t)) u_rsp_buf (
    .clk       (clk),
    .ext_rst_e (ext_rst_e),
    .in_valid  (mp_rsp_valid),
    .in_data   (mp_rsp_data),
    .in_ready  (mp_rsp_ready),
    .out_valid (rsp_valid),
    .out_data  (rsp_data),
    .out_ready (rsp_ready)
  );

endmodule

// ==== tb/dispatcher_chk.sv ====
`timescale 1ns/1ps

module dispatcher_chk (
  input logic                              clk,
  input logic                              ext_rst_e,
  input logic                              reply_valid,
  input logic                              reply_ready,
  input dispatcher_pkg::cpu_msg_e          reply_msg,
  input logic [dispatcher_pkg::ADDR_W-1:0] reply_addr,
  input logic [dispatcher_pkg::DATA_W-1:0] reply_wdata,
  input logic                              rsp_valid,
  input logic                              rsp_ready,
  input logic [dispatcher_pkg::DATA_W-1:0] rsp_rdata,
  input logic                              rsp_is_write,
  input logic                              cpu_q,
  input logic                              ext_read_q,
  input logic                              ext_write_q,
  input logic                              ext_bus_allow
);

  // number of failed assertions so far
  int unsigned fail_count = 0;

  // stalled reply held by the cpu
  reply_stable: assert property (@(posedge clk) disable iff (ext_rst_e)
    reply_valid && !reply_ready |=> reply_valid && $stable(reply_msg)
      && $stable(reply_addr) && $stable(reply_wdata))
    else begin
      fail_count++;
      $error("reply fields changed while the reply was stalled");
    end

  // stalled response held by the dispatcher
  rsp_stable: assert property (@(posedge clk) disable iff (ext_rst_e)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_is_write))
    else begin
      fail_count++;
      $error("response fields changed while the response was stalled");
    end

  // one external access kind at a time
  one_access: assert property (@(posedge clk) disable iff (ext_rst_e)
    !(ext_read_q && ext_write_q))
    else begin
      fail_count++;
      $error("external read and write requested together");
    end

  no_poll_on_grant: assert property (@(posedge clk) disable iff (ext_rst_e)
    !(ext_bus_allow && cpu_q))
    else begin
      fail_count++;
      $error("poll pulse while the external bus was granted");
    end

endmodule

bind dispatcher_top dispatcher_chk chk_i (
  .clk           (clk),
  .ext_rst_e     (ext_rst_e),
  .reply_valid   (reply_valid),
  .reply_ready   (reply_ready),
  .reply_msg     (reply_msg),
  .reply_addr    (reply_addr),
  .reply_wdata   (reply_wdata),
  .rsp_valid     (rsp_valid),
  .rsp_ready     (rsp_ready),
  .rsp_rdata     (rsp_rdata),
  .rsp_is_write  (rsp_is_write),
  .cpu_q         (cpu_q),
  .ext_read_q    (ext_read_q),
  .ext_write_q   (ext_write_q),
  .ext_bus_allow (ext_bus_allow)
);

// ==== tb/dispatcher_tb.sv ====
`timescale 1ns/1ps

module dispatcher_tb;

  localparam int NUM_POLLS   = 2000;
  localparam int CLK_NS      = 10;
  localparam int WAIT_CYCLES = 100;
  // run budget of 100 cycles per poll
  localparam int WATCHDOG_NS = NUM_POLLS * 100 * CLK_NS;

  logic                              clk;
  logic                              ext_rst_e;
  logic                              cpu_q;
  logic [dispatcher_pkg::IDX_W-1:0]  cpu_index;
  logic                              reply_valid;
  dispatcher_pkg::cpu_msg_e          reply_msg;
  logic [dispatcher_pkg::ADDR_W-1:0] reply_addr;
  logic [dispatcher_pkg::DATA_W-1:0] reply_wdata;
  logic                              reply_ready;
  logic                              rsp_valid;
  logic [dispatcher_pkg::DATA_W-1:0] rsp_rdata;
  logic                              rsp_is_write;
  logic                              rsp_ready;
  logic                              ext_read_q;
  logic                              ext_write_q;
  logic [dispatcher_pkg::ADDR_W-1:0] ext_mem_addr;
  logic [dispatcher_pkg::DATA_W-1:0] ext_mem_wdata;
  logic                              ext_read_dn;
  logic                              ext_write_dn;
  logic [dispatcher_pkg::DATA_W-1:0] ext_mem_rdata;
  logic                              ext_bus_q;
  logic                              ext_bus_allow;

  // one seed per process so each stream stays fixed
  integer seed = 32'h419e;
  integer mem_seed;
  integer rsp_seed;
  integer bus_seed;

  int errors;
  int polls;
  int mem_replies;
  int responses;
  int bus_grants;
  int peak_act;

  // reference poll state
  int act;
  int inact;
  int ptr;
  bit last_offer;

  // reference memory on the cpu side, external memory contents on the far side
  logic [31:0] ref_mem [logic [15:0]];
  logic [31:0] ext_mem [logic [15:0]];
  // {is_write, rdata} for every read or write reply in order
  logic [32:0] exp_rsp_q [$];

  // the external access the next request has to match
  bit          mem_pending;
  bit          exp_write;
  logic [15:0] exp_addr;
  logic [31:0] exp_wdata;

  dispatcher_top dut_i (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .cpu_q         (cpu_q),
    .cpu_index     (cpu_index),
    .reply_valid   (reply_valid),
    .reply_msg     (reply_msg),
    .reply_addr    (reply_addr),
    .reply_wdata   (reply_wdata),
    .reply_ready   (reply_ready),
    .rsp_valid     (rsp_valid),
    .rsp_rdata     (rsp_rdata),
    .rsp_is_write  (rsp_is_write),
    .rsp_ready     (rsp_ready),
    .ext_read_q    (ext_read_q),
    .ext_write_q   (ext_write_q),
    .ext_mem_addr  (ext_mem_addr),
    .ext_mem_wdata (ext_mem_wdata),
    .ext_read_dn   (ext_read_dn),
    .ext_write_dn  (ext_write_dn),
    .ext_mem_rdata (ext_mem_rdata),
    .ext_bus_q     (ext_bus_q),
    .ext_bus_allow (ext_bus_allow)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  task automatic compare_values(input logic [63:0] got, input logic [63:0] exp,
                                input string what);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("ERROR at %0t ns: %s", $time, what);
  endtask

  // every address bit shows up in an unwritten word
  function automatic logic [31:0] fill_word(input logic [15:0] a);
    return {a ^ 16'h5a3c, ~a};
  endfunction

  // poll rule alternates offers while slots remain
  task automatic predict_index(output logic [dispatcher_pkg::IDX_W-1:0] idx);
    int nxt;
    if ((inact > 0 && !last_offer) || act == 0) begin
      idx        = 4'b1000;
      last_offer = 1'b1;
    end else begin
      nxt = ptr + 1;
      if (nxt >= act) begin
        nxt = 0;
      end
      ptr        = nxt;
      idx        = 4'(nxt);
      last_offer = 1'b0;
    end
  endtask

  // misplaced start or end is ignored by the count rule
  task automatic apply_counts(input dispatcher_pkg::cpu_msg_e msg);
    if (msg == dispatcher_pkg::MSG_START && last_offer) begin
      act++;
      inact--;
    end
    if (msg == dispatcher_pkg::MSG_END && !last_offer) begin
      act--;
      inact++;
      ptr = 0;
    end
    if (act > peak_act) begin
      peak_act = act;
    end
  endtask

  task automatic wait_for_poll(output bit ok);
    int n;
    n = 0;
    @(posedge clk);
    while (!cpu_q && n < WAIT_CYCLES) begin
      @(posedge clk);
      n++;
    end
    ok = cpu_q;
  endtask

  task automatic send_reply(input dispatcher_pkg::cpu_msg_e msg, input logic [15:0] addr,
                            input logic [31:0] wdata, output bit ok);
    int d;
    int n;
    d = {$random(seed)} % 4;
    n = 0;
    repeat (d) @(posedge clk);
    #1;
    reply_valid = 1'b1;
    reply_msg   = msg;
    reply_addr  = addr;
    reply_wdata = wdata;
    @(posedge clk);
    while (!reply_ready && n < WAIT_CYCLES) begin
      @(posedge clk);
      n++;
    end
    ok = reply_ready;
    if (!ok) begin
      report_failure("the reply was never accepted by the dispatcher");
    end
    #1;
    reply_valid = 1'b0;
    reply_msg   = dispatcher_pkg::MSG_NONE;
  endtask

  initial begin : cpu_side
    bit                               ok;
    int                               r;
    logic [dispatcher_pkg::IDX_W-1:0] exp_idx;
    dispatcher_pkg::cpu_msg_e         msg;
    logic [15:0]                      addr;
    logic [31:0]                      wdata;
    ext_rst_e     = 1'b1;
    reply_valid   = 1'b0;
    reply_msg     = dispatcher_pkg::MSG_NONE;
    reply_addr    = '0;
    reply_wdata   = '0;
    rsp_ready     = 1'b0;
    ext_read_dn   = 1'b0;
    ext_write_dn  = 1'b0;
    ext_mem_rdata = '0;
    ext_bus_q     = 1'b0;
    mem_seed      = seed ^ 32'h0101;
    rsp_seed      = seed ^ 32'h0202;
    bus_seed      = seed ^ 32'h0303;
    act           = 0;
    inact         = dispatcher_pkg::CPU_SLOTS;
    ptr           = 0;
    last_offer    = 1'b0;
    ok            = 1'b1;
    repeat (10) @(posedge clk);
    #1 ext_rst_e = 1'b0;
    // idle outputs straight after reset
    compare_values(cpu_q, 1'b0, "cpu_q after reset");
    compare_values(ext_read_q | ext_write_q, 1'b0, "memory request after reset");
    compare_values(rsp_valid, 1'b0, "rsp_valid after reset");
    compare_values(ext_bus_allow, 1'b0, "ext_bus_allow after reset");
    while (polls < NUM_POLLS && ok) begin
      wait_for_poll(ok);
      if (!ok) begin
        report_failure("no poll pulse arrived within the wait limit");
      end else begin
        polls++;
        predict_index(exp_idx);
        compare_values(cpu_index, exp_idx, "cpu_index at poll");
        r     = {$random(seed)} % 10;
        addr  = 16'hc000 | 16'({$random(seed)} & 32'h3f);
        wdata = $random(seed);
        if (r == 0) msg = dispatcher_pkg::MSG_NONE;
        else if (r <= 3) msg = dispatcher_pkg::MSG_START;
        else if (r == 4) msg = dispatcher_pkg::MSG_END;
        else if (r <= 6) msg = dispatcher_pkg::MSG_READ;
        else msg = dispatcher_pkg::MSG_WRITE;
        if (msg == dispatcher_pkg::MSG_READ || msg == dispatcher_pkg::MSG_WRITE) begin
          exp_write   = (msg == dispatcher_pkg::MSG_WRITE);
          exp_addr    = addr;
          exp_wdata   = wdata;
          mem_pending = 1'b1;
          mem_replies++;
          if (exp_write) begin
            ref_mem[addr] = wdata;
            exp_rsp_q.push_back({1'b1, 32'h0});
          end else begin
            exp_rsp_q.push_back({1'b0, ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr)});
          end
        end
        apply_counts(msg);
        send_reply(msg, addr, wdata, ok);
      end
    end
    // the next poll only opens once the last response was taken
    if (ok) begin
      wait_for_poll(ok);
      if (!ok) begin
        report_failure("the dispatcher stopped polling after the last reply");
      end
    end
    compare_values(responses, mem_replies, "response count");
    if (exp_rsp_q.size() != 0) begin
      report_failure("responses were still outstanding at the end");
    end
    if (bus_grants == 0) begin
      report_failure("the external bus was never granted");
    end
    // offers must have been seen to stop with every slot taken
    if (peak_act != dispatcher_pkg::CPU_SLOTS) begin
      report_failure("the active count never reached the number of cpu slots");
    end
    errors += dut_i.chk_i.fail_count;
    $display("polls %0d, mem replies %0d, rsps %0d, bus grants %0d, peak active %0d, errors %0d",
             polls, mem_replies, responses, bus_grants, peak_act, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // external memory checks the request and answers after a random latency
  initial begin : ext_memory
    int lat;
    @(negedge ext_rst_e);
    forever begin
      @(posedge clk);
      if (ext_read_q || ext_write_q) begin
        if (!mem_pending) begin
          report_failure("external memory request without a read or write reply");
        end
        mem_pending = 1'b0;
        compare_values(ext_write_q, exp_write, "external request kind");
        compare_values(ext_mem_addr, exp_addr, "external request address");
        if (ext_write_q) begin
          compare_values(ext_mem_wdata, exp_wdata, "external write data");
        end
        lat = {$random(mem_seed)} % 8;
        repeat (lat) @(posedge clk);
        #1;
        if (ext_write_q) begin
          ext_mem[ext_mem_addr] = ext_mem_wdata;
          ext_write_dn = 1'b1;
        end else begin
          ext_mem_rdata = ext_mem.exists(ext_mem_addr) ? ext_mem[ext_mem_addr]
                                                       : fill_word(ext_mem_addr);
          ext_read_dn = 1'b1;
        end
        @(posedge clk);
        #1;
        ext_read_dn   = 1'b0;
        ext_write_dn  = 1'b0;
        // junk on the bus once done is gone
        ext_mem_rdata = $random(mem_seed);
      end
    end
  end

  // cpu response side with random stalls
  initial begin : rsp_sink
    logic [32:0] exp;
    @(negedge ext_rst_e);
    forever begin
      @(posedge clk);
      if (rsp_valid && rsp_ready) begin
        responses++;
        if (exp_rsp_q.size() == 0) begin
          report_failure("a response arrived with none outstanding");
        end else begin
          exp = exp_rsp_q.pop_front();
          compare_values(rsp_is_write, exp[32], "rsp_is_write");
          if (!exp[32]) begin
            compare_values(rsp_rdata, exp[31:0], "read data");
          end
        end
      end
      #1 rsp_ready = ({$random(rsp_seed)} % 4) != 0;
    end
  end

  // bursts on the external bus request
  initial begin : bus_master
    int gap;
    int hold;
    int n;
    @(negedge ext_rst_e);
    forever begin
      gap = 20 + {$random(bus_seed)} % 60;
      repeat (gap) @(posedge clk);
      #1 ext_bus_q = 1'b1;
      n = 0;
      @(posedge clk);
      while (!ext_bus_allow && n < WAIT_CYCLES) begin
        @(posedge clk);
        n++;
      end
      if (!ext_bus_allow) begin
        report_failure("the external bus request was never granted");
      end else begin
        bus_grants++;
      end
      hold = 1 + {$random(bus_seed)} % 15;
      repeat (hold) begin
        @(posedge clk);
        compare_values(ext_bus_allow, 1'b1, "ext_bus_allow during burst");
      end
      #1 ext_bus_q = 1'b0;
      // allow lasts one more cycle
      @(posedge clk);
      @(posedge clk);
      compare_values(ext_bus_allow, 1'b0, "ext_bus_allow after release");
    end
  end

  // nothing else touches the port while the bus is out
  always @(posedge clk) begin
    if (!ext_rst_e && ext_bus_allow && (cpu_q || ext_read_q || ext_write_q)) begin
      report_failure("poll or memory request while the external bus was granted");
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    report_failure("the watchdog expired before all polls were handled");
    $display("polls %0d, memory replies %0d, responses %0d, bus grants %0d, errors %0d",
             polls, mem_replies, responses, bus_grants, errors);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== all.f ====
rtl/dispatcher_pkg.sv
rtl/cpu_reply_decoder.sv
rtl/req_buffer.sv
rtl/cpu_scheduler.sv
rtl/ext_mem_port.sv
rtl/dispatcher_top.sv
tb/dispatcher_chk.sv
tb/dispatcher_tb.sv

// ==== Bender.yml ====
package:
  name: dispatcher

sources:
  # design
  - rtl/dispatcher_pkg.sv
  - rtl/cpu_reply_decoder.sv
  - rtl/req_buffer.sv
  - rtl/cpu_scheduler.sv
  - rtl/ext_mem_port.sv
  - rtl/dispatcher_top.sv

  # testbench
  - target: simulation
    files:
      - tb/dispatcher_chk.sv
      - tb/dispatcher_tb.sv
